// File: include/mem_defs.svh
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// byte address seen on each AXI port
`define MEM_ADDR_W 16

// data path
`define MEM_DATA_W 32
`define MEM_STRB_W 4

// word address into the shared RAM, 16K words
`define MEM_WORD_W 14

`endif

// File: source/mem_pkg.sv
`default_nettype none

`include "mem_defs.svh"

package mem_pkg;

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} axi_resp_e;

	typedef enum logic [2:0] {
		IDLE,
		WRITE,
		WRITE_RESP,
		READ_ADDR,
		READ_DATA,
		READ_RESP
	} ctrl_state_e;

	// write address channel
	typedef struct packed {
		logic [`MEM_ADDR_W-1:0] awaddr;
		logic [2:0]             awprot;
	} axi_aw_t;

	// write data channel
	typedef struct packed {
		logic [`MEM_DATA_W-1:0] wdata;
		logic [`MEM_STRB_W-1:0] wstrb;
	} axi_w_t;

	// write response channel
	typedef struct packed {
		axi_resp_e bresp;
	} axi_b_t;

	// read address channel
	typedef struct packed {
		logic [`MEM_ADDR_W-1:0] araddr;
		logic [2:0]             arprot;
	} axi_ar_t;

	// read data channel
	typedef struct packed {
		logic [`MEM_DATA_W-1:0] rdata;
		axi_resp_e              rresp;
	} axi_r_t;

	// one RAM port, driven by a controller
	typedef struct packed {
		logic                   en;
		logic [`MEM_STRB_W-1:0] we;
		logic [`MEM_WORD_W-1:0] addr;
		logic [`MEM_DATA_W-1:0] wrdata;
	} bram_req_t;

endpackage

`default_nettype wire

// File: source/dual_port_ram.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_defs.svh"

module dual_port_ram (
	input  logic                   clk,
	input  mem_pkg::bram_req_t     port_a,
	input  mem_pkg::bram_req_t     port_b,
	output logic [`MEM_DATA_W-1:0] rddata_a,
	output logic [`MEM_DATA_W-1:0] rddata_b
);

	logic [`MEM_DATA_W-1:0] mem [0:(2**`MEM_WORD_W)-1];

	mem_pkg::bram_req_t     req [2];
	logic [`MEM_DATA_W-1:0] rd  [2];

	assign req[0]   = port_a;
	assign req[1]   = port_b;
	assign rddata_a = rd[0];
	assign rddata_b = rd[1];

	// same logic on both ports, read-first
	for (genvar p = 0; p < 2; p++) begin : g_port
		always @(posedge clk) begin
			if (req[p].en) begin
				rd[p] <= mem[req[p].addr];
				for (int i = 0; i < `MEM_STRB_W; i++) begin
					if (req[p].we[i])
						mem[req[p].addr][8*i +: 8] <= req[p].wrdata[8*i +: 8];
				end
			end
		end
	end

	// colliding writes have no defined result
	assert property (@(posedge clk)
		(port_a.en && |port_a.we && port_b.en && |port_b.we)
		|-> (port_a.addr != port_b.addr));

endmodule

`default_nettype wire

// File: source/axi_bram_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_defs.svh"

module axi_bram_ctrl (
	input  logic                   clk,
	input  logic                   arst_n,

	input  mem_pkg::axi_aw_t       aw,
	input  logic                   awvalid,
	output logic                   awready,

	input  mem_pkg::axi_w_t        w,
	input  logic                   wvalid,
	output logic                   wready,

	output mem_pkg::axi_b_t        b,
	output logic                   bvalid,
	input  logic                   bready,

	input  mem_pkg::axi_ar_t       ar,
	input  logic                   arvalid,
	output logic                   arready,

	output mem_pkg::axi_r_t        r,
	output logic                   rvalid,
	input  logic                   rready,

	output mem_pkg::bram_req_t     bram,
	input  logic [`MEM_DATA_W-1:0] rddata
);

	mem_pkg::ctrl_state_e state;

	// early AW or W kept until its partner shows up
	logic             aw_held;
	logic             w_held;
	mem_pkg::axi_aw_t aw_q;
	mem_pkg::axi_w_t  w_q;

	mem_pkg::axi_aw_t aw_cur;
	mem_pkg::axi_w_t  w_cur;
	logic             idle;
	logic             wr_go;
	logic             rd_go;

	// request latched at the start of a transaction
	logic [`MEM_WORD_W-1:0] addr_q;
	logic [`MEM_DATA_W-1:0] wdata_q;
	logic [`MEM_STRB_W-1:0] wstrb_q;
	logic                   err_q;

	assign idle   = (state == mem_pkg::IDLE);
	assign aw_cur = aw_held ? aw_q : aw;
	assign w_cur  = w_held ? w_q : w;

	assign awready = idle && !aw_held;
	assign wready  = idle && !w_held;
	// write wins over a read in the same cycle
	assign wr_go   = idle && (aw_held || awvalid) && (w_held || wvalid);
	assign arready = idle && !wr_go;
	assign rd_go   = arvalid && arready;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= mem_pkg::IDLE;
			aw_held <= 1'b0;
			w_held  <= 1'b0;
			bvalid  <= 1'b0;
			rvalid  <= 1'b0;
		end else begin
			unique case (state)
				mem_pkg::IDLE: begin
					if (wr_go) begin
						state   <= mem_pkg::WRITE;
						aw_held <= 1'b0;
						w_held  <= 1'b0;
					end else begin
						if (awvalid && awready)
							aw_held <= 1'b1;
						if (wvalid && wready)
							w_held <= 1'b1;
						if (rd_go)
							state <= mem_pkg::READ_ADDR;
					end
				end
				mem_pkg::WRITE: begin
					state <= mem_pkg::WRITE_RESP;
				end
				mem_pkg::WRITE_RESP: begin
					if (!bvalid) begin
						bvalid <= 1'b1;
					end else if (bready) begin
						bvalid <= 1'b0;
						state  <= mem_pkg::IDLE;
					end
				end
				mem_pkg::READ_ADDR: begin
					state <= mem_pkg::READ_DATA;
				end
				mem_pkg::READ_DATA: begin
					state <= mem_pkg::READ_RESP;
				end
				mem_pkg::READ_RESP: begin
					if (!rvalid) begin
						rvalid <= 1'b1;
					end else if (rready) begin
						rvalid <= 1'b0;
						state  <= mem_pkg::IDLE;
					end
				end
				default: begin
					state <= mem_pkg::IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (awvalid && awready)
			aw_q <= aw;
		if (wvalid && wready)
			w_q <= w;
		if (wr_go) begin
			addr_q  <= aw_cur.awaddr[`MEM_ADDR_W-1:2];
			err_q   <= |aw_cur.awaddr[1:0];
			wdata_q <= w_cur.wdata;
			wstrb_q <= w_cur.wstrb;
		end else if (rd_go) begin
			addr_q <= ar.araddr[`MEM_ADDR_W-1:2];
			err_q  <= |ar.araddr[1:0];
		end
		// RAM output is valid the cycle after en
		if (state == mem_pkg::READ_DATA) begin
			r.rdata <= err_q ? '0 : rddata;
			r.rresp <= err_q ? mem_pkg::SLVERR : mem_pkg::OKAY;
		end
	end

	assign b.bresp = err_q ? mem_pkg::SLVERR : mem_pkg::OKAY;

	// unaligned requests never reach the RAM
	assign bram.en     = ((state == mem_pkg::WRITE) || (state == mem_pkg::READ_ADDR)) && !err_q;
	assign bram.we     = ((state == mem_pkg::WRITE) && !err_q) ? wstrb_q : '0;
	assign bram.addr   = addr_q;
	assign bram.wrdata = wdata_q;

	assert property (@(posedge clk) disable iff (!arst_n)
		bvalid && !bready |=> bvalid);

	assert property (@(posedge clk) disable iff (!arst_n)
		rvalid && !rready |=> rvalid && $stable(r));

	// no new request accepted while a response is still pending
	assert property (@(posedge clk) disable iff (!arst_n)
		(bvalid || rvalid) |-> !arready && !awready && !wready);

endmodule

`default_nettype wire

// File: source/mem_subsystem.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_defs.svh"

module mem_subsystem (
	input  logic              clk,
	input  logic              arst_n,

	// instruction fetch port
	input  mem_pkg::axi_aw_t  imem_aw,
	input  logic              imem_awvalid,
	output logic              imem_awready,
	input  mem_pkg::axi_w_t   imem_w,
	input  logic              imem_wvalid,
	output logic              imem_wready,
	output mem_pkg::axi_b_t   imem_b,
	output logic              imem_bvalid,
	input  logic              imem_bready,
	input  mem_pkg::axi_ar_t  imem_ar,
	input  logic              imem_arvalid,
	output logic              imem_arready,
	output mem_pkg::axi_r_t   imem_r,
	output logic              imem_rvalid,
	input  logic              imem_rready,

	// data port
	input  mem_pkg::axi_aw_t  dmem_aw,
	input  logic              dmem_awvalid,
	output logic              dmem_awready,
	input  mem_pkg::axi_w_t   dmem_w,
	input  logic              dmem_wvalid,
	output logic              dmem_wready,
	output mem_pkg::axi_b_t   dmem_b,
	output logic              dmem_bvalid,
	input  logic              dmem_bready,
	input  mem_pkg::axi_ar_t  dmem_ar,
	input  logic              dmem_arvalid,
	output logic              dmem_arready,
	output mem_pkg::axi_r_t   dmem_r,
	output logic              dmem_rvalid,
	input  logic              dmem_rready
);

	mem_pkg::bram_req_t     imem_bram;
	mem_pkg::bram_req_t     dmem_bram;
	logic [`MEM_DATA_W-1:0] imem_rddata;
	logic [`MEM_DATA_W-1:0] dmem_rddata;

	axi_bram_ctrl imem_ctrl (
		.clk(clk), .arst_n(arst_n),
		.aw(imem_aw), .awvalid(imem_awvalid), .awready(imem_awready),
		.w(imem_w), .wvalid(imem_wvalid), .wready(imem_wready),
		.b(imem_b), .bvalid(imem_bvalid), .bready(imem_bready),
		.ar(imem_ar), .arvalid(imem_arvalid), .arready(imem_arready),
		.r(imem_r), .rvalid(imem_rvalid), .rready(imem_rready),
		.bram(imem_bram), .rddata(imem_rddata)
	);

	axi_bram_ctrl dmem_ctrl (
		.clk(clk), .arst_n(arst_n),
		.aw(dmem_aw), .awvalid(dmem_awvalid), .awready(dmem_awready),
		.w(dmem_w), .wvalid(dmem_wvalid), .wready(dmem_wready),
		.b(dmem_b), .bvalid(dmem_bvalid), .bready(dmem_bready),
		.ar(dmem_ar), .arvalid(dmem_arvalid), .arready(dmem_arready),
		.r(dmem_r), .rvalid(dmem_rvalid), .rready(dmem_rready),
		.bram(dmem_bram), .rddata(dmem_rddata)
	);

	// imem on port a, dmem on port b
	dual_port_ram ram0 (
		.clk(clk),
		.port_a(imem_bram),
		.port_b(dmem_bram),
		.rddata_a(imem_rddata),
		.rddata_b(dmem_rddata)
	);

endmodule

`default_nettype wire

// File: verification/axi_lite_master.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_defs.svh"

module axi_lite_master (
	input  logic             clk,
	output mem_pkg::axi_aw_t aw,
	output logic             awvalid,
	input  logic             awready,
	output mem_pkg::axi_w_t  w,
	output logic             wvalid,
	input  logic             wready,
	input  mem_pkg::axi_b_t  b,
	input  logic             bvalid,
	output logic             bready,
	output mem_pkg::axi_ar_t ar,
	output logic             arvalid,
	input  logic             arready,
	input  mem_pkg::axi_r_t  r,
	input  logic             rvalid,
	output logic             rready
);

	initial begin
		aw      = '0;
		awvalid = 1'b0;
		w       = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		ar      = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
	end

	// order 0 sends AW and W together, 1 sends AW first, 2 sends W first
	task automatic write_word(input logic [`MEM_ADDR_W-1:0] addr,
		input logic [`MEM_STRB_W-1:0] strb, input logic [`MEM_DATA_W-1:0] data,
		input logic [1:0] order, output logic [1:0] resp);
		logic aw_done;
		logic w_done;
		logic b_done;
		@(negedge clk);
		aw      = '{awaddr: addr, awprot: 3'b000};
		w       = '{wdata: data, wstrb: strb};
		awvalid = (order != 2'd2);
		wvalid  = (order != 2'd1);
		bready  = 1'b1;
		aw_done = 1'b0;
		w_done  = 1'b0;
		b_done  = 1'b0;
		while (!b_done) begin
			@(posedge clk);
			if (awvalid && awready)
				aw_done = 1'b1;
			if (wvalid && wready)
				w_done = 1'b1;
			if (bvalid && bready) begin
				b_done = 1'b1;
				resp   = b.bresp;
			end
			@(negedge clk);
			awvalid = !aw_done && ((order != 2'd2) || w_done);
			wvalid  = !w_done && ((order != 2'd1) || aw_done);
		end
		bready = 1'b0;
	endtask

	// rready stays low for the first stall cycles of rvalid
	task automatic read_word(input logic [`MEM_ADDR_W-1:0] addr, input logic [3:0] stall,
		output logic [`MEM_DATA_W-1:0] data, output logic [1:0] resp);
		logic ar_done;
		logic r_done;
		int   held;
		@(negedge clk);
		ar      = '{araddr: addr, arprot: 3'b000};
		arvalid = 1'b1;
		rready  = (stall == 4'd0);
		ar_done = 1'b0;
		r_done  = 1'b0;
		held    = 0;
		while (!r_done) begin
			@(posedge clk);
			if (arvalid && arready)
				ar_done = 1'b1;
			if (rvalid && rready) begin
				r_done = 1'b1;
				data   = r.rdata;
				resp   = r.rresp;
			end else if (rvalid) begin
				held++;
			end
			@(negedge clk);
			arvalid = !ar_done;
			rready  = !r_done && (held >= stall);
		end
	endtask

endmodule

`default_nettype wire

// File: verification/mem_subsystem_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_defs.svh"

module mem_subsystem_tb;

	localparam int ROWS  = 19;
	localparam int LIMIT = ROWS * 20 + 100;

	typedef struct packed {
		logic                   par;
		logic                   port;
		logic                   rd;
		logic [`MEM_ADDR_W-1:0] addr;
		logic [`MEM_STRB_W-1:0] strb;
		logic [`MEM_DATA_W-1:0] data;
		logic                   rnd;
		logic [1:0]             order;
		logic [3:0]             stall;
	} row_t;

	logic             clk = 1'b0;
	logic             arst_n;
	mem_pkg::axi_aw_t imem_aw, dmem_aw;
	mem_pkg::axi_w_t  imem_w, dmem_w;
	mem_pkg::axi_b_t  imem_b, dmem_b;
	mem_pkg::axi_ar_t imem_ar, dmem_ar;
	mem_pkg::axi_r_t  imem_r, dmem_r;
	logic imem_awvalid, imem_awready, imem_wvalid, imem_wready, imem_bvalid, imem_bready;
	logic imem_arvalid, imem_arready, imem_rvalid, imem_rready;
	logic dmem_awvalid, dmem_awready, dmem_wvalid, dmem_wready, dmem_bvalid, dmem_bready;
	logic dmem_arvalid, dmem_arready, dmem_rvalid, dmem_rready;

	row_t                   rows [ROWS];
	logic [`MEM_DATA_W-1:0] ref_mem [0:(2**`MEM_WORD_W)-1];
	logic [31:0]            lfsr   = 32'h49c9_16fd;
	int                     cycles = 0;
	int                     checks = 0;
	int                     errors = 0;
	int                     i;

	always #50 clk = ~clk;

	mem_subsystem dut0 (.*);

	axi_lite_master imem_mst (
		.clk(clk),
		.aw(imem_aw), .awvalid(imem_awvalid), .awready(imem_awready),
		.w(imem_w), .wvalid(imem_wvalid), .wready(imem_wready),
		.b(imem_b), .bvalid(imem_bvalid), .bready(imem_bready),
		.ar(imem_ar), .arvalid(imem_arvalid), .arready(imem_arready),
		.r(imem_r), .rvalid(imem_rvalid), .rready(imem_rready)
	);

	axi_lite_master dmem_mst (
		.clk(clk),
		.aw(dmem_aw), .awvalid(dmem_awvalid), .awready(dmem_awready),
		.w(dmem_w), .wvalid(dmem_wvalid), .wready(dmem_wready),
		.b(dmem_b), .bvalid(dmem_bvalid), .bready(dmem_bready),
		.ar(dmem_ar), .arvalid(dmem_arvalid), .arready(dmem_arready),
		.r(dmem_r), .rvalid(dmem_rvalid), .rready(dmem_rready)
	);

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one step per bit taken
	function logic [31:0] rand_word();
		logic [31:0] v;
		for (int k = 0; k < 32; k++) begin
			lfsr = lfsr_step(lfsr);
			v[k] = lfsr[0];
		end
		return v;
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			$display("Mismatch %s: expected %h, got %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic run_row(input int n);
		row_t                   rw;
		string                  pname;
		int                     wa;
		logic [`MEM_DATA_W-1:0] data;
		logic [`MEM_DATA_W-1:0] exp_data;
		logic [1:0]             resp;
		logic [1:0]             exp_resp;
		rw       = rows[n];
		pname    = rw.port ? "dmem" : "imem";
		wa       = rw.addr[`MEM_ADDR_W-1:2];
		exp_resp = (rw.addr[1:0] != 2'b00) ? mem_pkg::SLVERR : mem_pkg::OKAY;
		if (!rw.rd) begin
			data = rw.rnd ? rand_word() : rw.data;
			if (rw.port)
				dmem_mst.write_word(rw.addr, rw.strb, data, rw.order, resp);
			else
				imem_mst.write_word(rw.addr, rw.strb, data, rw.order, resp);
			// unaligned write leaves memory alone
			if (exp_resp == mem_pkg::OKAY) begin
				for (int k = 0; k < `MEM_STRB_W; k++) begin
					if (rw.strb[k])
						ref_mem[wa][8*k +: 8] = data[8*k +: 8];
				end
			end
			check_val({pname, " bresp"}, exp_resp, resp);
		end else begin
			exp_data = (exp_resp == mem_pkg::OKAY) ? ref_mem[wa] : '0;
			if (rw.port)
				dmem_mst.read_word(rw.addr, rw.stall, data, resp);
			else
				imem_mst.read_word(rw.addr, rw.stall, data, resp);
			check_val({pname, " rresp"}, exp_resp, resp);
			check_val({pname, " rdata"}, exp_data, data);
		end
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles > LIMIT) begin
			$display("Timeout: tests did not finish within %0d cycles", LIMIT);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	initial begin
		// par, port (1 dmem), rd, addr, strb, data, rnd, order, stall
		rows[0]  = '{1'b0, 1'b1, 1'b0, 16'h0010, 4'hf, 32'hdead_beef, 1'b0, 2'd0, 4'd0};
		rows[1]  = '{1'b0, 1'b1, 1'b0, 16'h0014, 4'hf, 32'h0, 1'b1, 2'd1, 4'd0};
		rows[2]  = '{1'b0, 1'b1, 1'b1, 16'h0010, 4'h0, 32'h0, 1'b0, 2'd0, 4'd0};
		rows[3]  = '{1'b0, 1'b1, 1'b1, 16'h0014, 4'h0, 32'h0, 1'b0, 2'd0, 4'd0};
		rows[4]  = '{1'b0, 1'b1, 1'b0, 16'h0010, 4'h5, 32'h1122_3344, 1'b0, 2'd2, 4'd0};
		rows[5]  = '{1'b0, 1'b1, 1'b1, 16'h0010, 4'h0, 32'h0, 1'b0, 2'd0, 4'd0};
		rows[6]  = '{1'b0, 1'b1, 1'b0, 16'h0014, 4'h8, 32'h0, 1'b1, 2'd0, 4'd0};
		rows[7]  = '{1'b0, 1'b0, 1'b1, 16'h0014, 4'h0, 32'h0, 1'b0, 2'd0, 4'd0};
		rows[8]  = '{1'b0, 1'b0, 1'b0, 16'h0100, 4'hf, 32'h0, 1'b1, 2'd1, 4'd0};
		rows[9]  = '{1'b0, 1'b1, 1'b1, 16'h0100, 4'h0, 32'h0, 1'b0, 2'd0, 4'd0};
		rows[10] = '{1'b0, 1'b1, 1'b0, 16'h0102, 4'hf, 32'h5555_aaaa, 1'b0, 2'd0, 4'd0};
		rows[11] = '{1'b0, 1'b0, 1'b1, 16'h0101, 4'h0, 32'h0, 1'b0, 2'd0, 4'd0};
		rows[12] = '{1'b0, 1'b1, 1'b1, 16'h0100, 4'h0, 32'h0, 1'b0, 2'd0, 4'd0};
		rows[13] = '{1'b1, 1'b0, 1'b0, 16'h0200, 4'hf, 32'h0, 1'b1, 2'd0, 4'd0};
		rows[14] = '{1'b0, 1'b1, 1'b0, 16'h0300, 4'hf, 32'h0, 1'b1, 2'd2, 4'd0};
		rows[15] = '{1'b1, 1'b0, 1'b1, 16'h0300, 4'h0, 32'h0, 1'b0, 2'd0, 4'd5};
		rows[16] = '{1'b0, 1'b1, 1'b1, 16'h0200, 4'h0, 32'h0, 1'b0, 2'd0, 4'd3};
		rows[17] = '{1'b0, 1'b0, 1'b0, 16'h0303, 4'hf, 32'h0bad_0bad, 1'b0, 2'd0, 4'd0};
		rows[18] = '{1'b0, 1'b1, 1'b1, 16'h0300, 4'h0, 32'h0, 1'b0, 2'd0, 4'd2};

		arst_n = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);
		check_val("bvalid/rvalid after reset", 32'h0,
			{imem_bvalid, imem_rvalid, dmem_bvalid, dmem_rvalid});
		check_val("awready/wready/arready after reset", 32'h3f,
			{imem_awready, imem_wready, imem_arready, dmem_awready, dmem_wready, dmem_arready});

		i = 0;
		while (i < ROWS) begin
			if (rows[i].par && (i + 1 < ROWS)) begin
				fork
					run_row(i);
					run_row(i + 1);
				join
				i += 2;
			end else begin
				run_row(i);
				i++;
			end
		end

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+include
source/mem_pkg.sv
source/dual_port_ram.sv
source/axi_bram_ctrl.sv
source/mem_subsystem.sv
verification/axi_lite_master.sv
verification/mem_subsystem_tb.sv
